//--- common/sysctrl_pkg.sv
package sysctrl_pkg;

    // ========================================
    // bus geometry
    // ========================================
    localparam int DATA_W = 32;
    localparam int OFS_W  = 8;

    // only the bits above the offset field are compared.
    localparam logic [DATA_W-1:0] BASE_ADR = 32'h2F00_0000;

    // ========================================
    // register offsets
    // ========================================
    localparam logic [OFS_W-1:0] OFS_PWRGOOD  = 8'h00; // read-only status.
    localparam logic [OFS_W-1:0] OFS_CLK_OUT  = 8'h04;
    localparam logic [OFS_W-1:0] OFS_TRAP_OUT = 8'h08;
    localparam logic [OFS_W-1:0] OFS_IRQ_SRC  = 8'h0C;
    localparam logic [OFS_W-1:0] OFS_PWR_LOSS = 8'h10; // write one to clear.

endpackage

//--- src/sysctrl_bus.sv
`timescale 1ns/1ps

module sysctrl_bus (
    input  logic                            clk,
    input  logic                            resetn,

    input  logic                            cyc_i,
    input  logic                            stb_i,
    input  logic                            we_i,
    input  logic [3:0]                      sel_i,
    input  logic [sysctrl_pkg::DATA_W-1:0]  adr_i,
    input  logic [sysctrl_pkg::DATA_W-1:0]  dat_i,

    input  logic                            regs_hit_i,
    input  logic [sysctrl_pkg::DATA_W-1:0]  regs_rdata_i,
    input  logic                            mon_hit_i,
    input  logic [sysctrl_pkg::DATA_W-1:0]  mon_rdata_i,

    output logic                            req_o,
    output logic [sysctrl_pkg::OFS_W-1:0]   ofs_o,
    output logic                            wen_o,
    output logic [sysctrl_pkg::DATA_W-1:0]  wdata_o,

    output logic [sysctrl_pkg::DATA_W-1:0]  dat_o,
    output logic                            ack_o,
    output logic                            err_o
);

    logic base_match;
    logic any_hit;

    // ========================================
    // request qualification
    // ========================================
    assign base_match = (adr_i[sysctrl_pkg::DATA_W-1:sysctrl_pkg::OFS_W] ==
                         sysctrl_pkg::BASE_ADR[sysctrl_pkg::DATA_W-1:sysctrl_pkg::OFS_W]);

    // a held request is not taken again while its response is out.
    assign req_o   = cyc_i && stb_i && base_match && !ack_o && !err_o;
    assign ofs_o   = adr_i[sysctrl_pkg::OFS_W-1:0];
    assign wen_o   = we_i && sel_i[0]; // lane 0 only, upper lanes ignored.
    assign wdata_o = dat_i;

    // ========================================
    // response
    // ========================================
    assign any_hit = regs_hit_i || mon_hit_i;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
        end else begin
            ack_o <= req_o && any_hit;
            err_o <= req_o && !any_hit; // in-base but unmapped.
        end
    end

    // parts return zero unless they hit on the previous edge.
    assign dat_o = regs_rdata_i | mon_rdata_i;

endmodule

//--- sysctrl_regs/sysctrl_regs.sv
`timescale 1ns/1ps

module sysctrl_regs (
    input  logic                            clk,
    input  logic                            resetn,

    input  logic                            req_i,
    input  logic [sysctrl_pkg::OFS_W-1:0]   ofs_i,
    input  logic                            wen_i,
    input  logic [sysctrl_pkg::DATA_W-1:0]  wdata_i,

    output logic                            hit_o,
    output logic [sysctrl_pkg::DATA_W-1:0]  rdata_o,

    output logic                            clk1_output_dest_o,
    output logic                            clk2_output_dest_o,
    output logic                            trap_output_dest_o,
    output logic                            irq_7_inputsrc_o,
    output logic                            irq_8_inputsrc_o
);

    logic                           clk_out_sel;
    logic                           trap_out_sel;
    logic                           irq_src_sel;
    logic [sysctrl_pkg::DATA_W-1:0] rd_word;

    // ========================================
    // decode
    // ========================================
    assign clk_out_sel  = req_i && (ofs_i == sysctrl_pkg::OFS_CLK_OUT);
    assign trap_out_sel = req_i && (ofs_i == sysctrl_pkg::OFS_TRAP_OUT);
    assign irq_src_sel  = req_i && (ofs_i == sysctrl_pkg::OFS_IRQ_SRC);

    assign hit_o = clk_out_sel || trap_out_sel || irq_src_sel;

    // ========================================
    // control bits
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            clk1_output_dest_o <= 1'b0;
            clk2_output_dest_o <= 1'b0;
            trap_output_dest_o <= 1'b0;
            irq_7_inputsrc_o   <= 1'b0;
            irq_8_inputsrc_o   <= 1'b0;
        end else if (wen_i) begin
            if (clk_out_sel) begin
                clk1_output_dest_o <= wdata_i[0];
                clk2_output_dest_o <= wdata_i[1];
            end
            if (trap_out_sel) begin
                trap_output_dest_o <= wdata_i[0];
            end
            if (irq_src_sel) begin
                irq_7_inputsrc_o <= wdata_i[0];
                irq_8_inputsrc_o <= wdata_i[1];
            end
        end
    end

    // read word built from the value before any write at this edge.
    always_comb begin
        rd_word = '0;
        if (clk_out_sel) begin
            rd_word[1:0] = {clk2_output_dest_o, clk1_output_dest_o};
        end else if (trap_out_sel) begin
            rd_word[0] = trap_output_dest_o;
        end else if (irq_src_sel) begin
            rd_word[1:0] = {irq_8_inputsrc_o, irq_7_inputsrc_o};
        end
    end

    always_ff @(posedge clk) begin
        rdata_o <= rd_word; // zero when not hit.
    end

endmodule

//--- pwrgood_mon/pwrgood_mon.sv
`timescale 1ns/1ps

module pwrgood_mon (
    input  logic                            clk,
    input  logic                            resetn,

    input  logic                            req_i,
    input  logic [sysctrl_pkg::OFS_W-1:0]   ofs_i,
    input  logic                            wen_i,
    input  logic [sysctrl_pkg::DATA_W-1:0]  wdata_i,

    input  logic                            usr1_pwrgood_i,
    input  logic                            usr2_pwrgood_i,

    output logic                            hit_o,
    output logic [sysctrl_pkg::DATA_W-1:0]  rdata_o,
    output logic [1:0]                      pwr_lost_o
);

    logic [1:0]                     sync_meta;
    logic [1:0]                     sync_good;
    logic [1:0]                     good_prev;
    logic [1:0]                     fall;
    logic [1:0]                     clr;
    logic                           status_sel;
    logic                           loss_sel;
    logic [sysctrl_pkg::DATA_W-1:0] rd_word;

    // ========================================
    // synchronizers
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            sync_meta <= 2'b00;
            sync_good <= 2'b00;
            good_prev <= 2'b00; // no false fall out of reset.
        end else begin
            sync_meta <= {usr2_pwrgood_i, usr1_pwrgood_i};
            sync_good <= sync_meta;
            good_prev <= sync_good;
        end
    end

    assign fall = good_prev & ~sync_good;

    // ========================================
    // decode and sticky flags
    // ========================================
    assign status_sel = req_i && (ofs_i == sysctrl_pkg::OFS_PWRGOOD);
    assign loss_sel   = req_i && (ofs_i == sysctrl_pkg::OFS_PWR_LOSS);
    assign hit_o      = status_sel || loss_sel;

    assign clr = (loss_sel && wen_i) ? wdata_i[1:0] : 2'b00;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pwr_lost_o <= 2'b00;
        end else begin
            pwr_lost_o <= (pwr_lost_o & ~clr) | fall; // a new fall beats the clear.
        end
    end

    // status word is read-only; writes to it are dropped.
    always_comb begin
        rd_word = '0;
        if (status_sel) begin
            rd_word[1:0] = sync_good;
        end else if (loss_sel) begin
            rd_word[1:0] = pwr_lost_o;
        end
    end

    always_ff @(posedge clk) begin
        rdata_o <= rd_word;
    end

endmodule

//--- src/sysctrl_wb.sv
`timescale 1ns/1ps

module sysctrl_wb (
    input  logic                            clk,
    input  logic                            resetn,

    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [3:0]                      wb_sel_i,
    input  logic [sysctrl_pkg::DATA_W-1:0]  wb_adr_i,
    input  logic [sysctrl_pkg::DATA_W-1:0]  wb_dat_i,
    output logic [sysctrl_pkg::DATA_W-1:0]  wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,

    input  logic                            usr1_pwrgood_i,
    input  logic                            usr2_pwrgood_i,

    output logic                            clk1_output_dest_o,
    output logic                            clk2_output_dest_o,
    output logic                            trap_output_dest_o,
    output logic                            irq_7_inputsrc_o,
    output logic                            irq_8_inputsrc_o,
    output logic [1:0]                      pwr_lost_o
);

    logic                           req;
    logic [sysctrl_pkg::OFS_W-1:0]  ofs;
    logic                           wen;
    logic [sysctrl_pkg::DATA_W-1:0] wdata;
    logic                           regs_hit;
    logic [sysctrl_pkg::DATA_W-1:0] regs_rdata;
    logic                           mon_hit;
    logic [sysctrl_pkg::DATA_W-1:0] mon_rdata;

    // ========================================
    // bus front end
    // ========================================
    sysctrl_bus u_bus (
        .clk          (clk),
        .resetn       (resetn),
        .cyc_i        (wb_cyc_i),
        .stb_i        (wb_stb_i),
        .we_i         (wb_we_i),
        .sel_i        (wb_sel_i),
        .adr_i        (wb_adr_i),
        .dat_i        (wb_dat_i),
        .regs_hit_i   (regs_hit),
        .regs_rdata_i (regs_rdata),
        .mon_hit_i    (mon_hit),
        .mon_rdata_i  (mon_rdata),
        .req_o        (req),
        .ofs_o        (ofs),
        .wen_o        (wen),
        .wdata_o      (wdata),
        .dat_o        (wb_dat_o),
        .ack_o        (wb_ack_o),
        .err_o        (wb_err_o)
    );

    // ========================================
    // register parts
    // ========================================
    sysctrl_regs u_regs (
        .clk                (clk),
        .resetn             (resetn),
        .req_i              (req),
        .ofs_i              (ofs),
        .wen_i              (wen),
        .wdata_i            (wdata),
        .hit_o              (regs_hit),
        .rdata_o            (regs_rdata),
        .clk1_output_dest_o (clk1_output_dest_o),
        .clk2_output_dest_o (clk2_output_dest_o),
        .trap_output_dest_o (trap_output_dest_o),
        .irq_7_inputsrc_o   (irq_7_inputsrc_o),
        .irq_8_inputsrc_o   (irq_8_inputsrc_o)
    );

    pwrgood_mon u_mon (
        .clk            (clk),
        .resetn         (resetn),
        .req_i          (req),
        .ofs_i          (ofs),
        .wen_i          (wen),
        .wdata_i        (wdata),
        .usr1_pwrgood_i (usr1_pwrgood_i),
        .usr2_pwrgood_i (usr2_pwrgood_i),
        .hit_o          (mon_hit),
        .rdata_o        (mon_rdata),
        .pwr_lost_o     (pwr_lost_o)
    );

endmodule

//--- tests/sysctrl_checker.sv
`timescale 1ns/1ps

module sysctrl_checker (
    input logic        clk,
    input logic        resetn,
    input logic        wb_cyc_i,
    input logic        wb_stb_i,
    input logic        wb_we_i,
    input logic [3:0]  wb_sel_i,
    input logic [31:0] wb_adr_i,
    input logic [31:0] wb_dat_i,
    input logic [31:0] wb_dat_o,
    input logic        wb_ack_o,
    input logic        wb_err_o,
    input logic        usr1_pwrgood_i,
    input logic        usr2_pwrgood_i,
    input logic        clk1_output_dest_o,
    input logic        clk2_output_dest_o,
    input logic        trap_output_dest_o,
    input logic        irq_7_inputsrc_o,
    input logic        irq_8_inputsrc_o,
    input logic [1:0]  pwr_lost_o
);

    string       test_name = "none";
    int          checks = 0;
    int          errors = 0;

    logic [1:0]  clk_out;
    logic        trap_out;
    logic [1:0]  irq_src;
    logic [1:0]  sync_meta;
    logic [1:0]  sync_good;
    logic [1:0]  good_prev;
    logic [1:0]  lost;
    logic [1:0]  clr;
    logic [7:0]  ofs;
    logic        req;
    logic        mapped;
    logic        pend_ack;
    logic        pend_err;
    logic [31:0] pend_data;

    // word a read returns, from the state held before the access.
    function automatic logic [31:0] expected_rdata(input logic [7:0] o);
        case (o)
            sysctrl_pkg::OFS_PWRGOOD:  return {30'd0, sync_good};
            sysctrl_pkg::OFS_CLK_OUT:  return {30'd0, clk_out};
            sysctrl_pkg::OFS_TRAP_OUT: return {31'd0, trap_out};
            sysctrl_pkg::OFS_IRQ_SRC:  return {30'd0, irq_src};
            sysctrl_pkg::OFS_PWR_LOSS: return {30'd0, lost};
            default:                   return 32'd0;
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("** Error [%s] %s: expected %h, actual %h",
                     test_name, what, exp_val, act_val);
        end
    endtask

    // ========================================
    // model update and compare
    // ========================================
    always @(posedge clk) begin
        if (!resetn) begin
            clk_out   = 2'b00;
            trap_out  = 1'b0;
            irq_src   = 2'b00;
            sync_meta = 2'b00;
            sync_good = 2'b00;
            good_prev = 2'b00;
            lost      = 2'b00;
            pend_ack  = 1'b0;
            pend_err  = 1'b0;
        end else begin
            compare("ack/err", {30'd0, pend_ack, pend_err}, {30'd0, wb_ack_o, wb_err_o});
            if (pend_ack) begin
                compare("read data", pend_data, wb_dat_o);
            end
            compare("control outputs", {27'd0, trap_out, irq_src, clk_out},
                    {27'd0, trap_output_dest_o, irq_8_inputsrc_o, irq_7_inputsrc_o,
                     clk2_output_dest_o, clk1_output_dest_o});
            compare("pwr_lost_o", {30'd0, lost}, {30'd0, pwr_lost_o});

            ofs = wb_adr_i[7:0];
            req = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o &&
                  (wb_adr_i[31:8] == sysctrl_pkg::BASE_ADR[31:8]);
            mapped = ofs inside {sysctrl_pkg::OFS_PWRGOOD, sysctrl_pkg::OFS_CLK_OUT,
                                 sysctrl_pkg::OFS_TRAP_OUT, sysctrl_pkg::OFS_IRQ_SRC,
                                 sysctrl_pkg::OFS_PWR_LOSS};
            pend_ack  = req && mapped;
            pend_err  = req && !mapped;
            pend_data = expected_rdata(ofs);

            clr = 2'b00;
            if (req && wb_we_i && wb_sel_i[0]) begin // lane 0 only.
                case (ofs)
                    sysctrl_pkg::OFS_CLK_OUT:  clk_out  = wb_dat_i[1:0];
                    sysctrl_pkg::OFS_TRAP_OUT: trap_out = wb_dat_i[0];
                    sysctrl_pkg::OFS_IRQ_SRC:  irq_src  = wb_dat_i[1:0];
                    sysctrl_pkg::OFS_PWR_LOSS: clr      = wb_dat_i[1:0];
                    default: ;
                endcase
            end
            lost      = (lost & ~clr) | (good_prev & ~sync_good);
            good_prev = sync_good;
            sync_good = sync_meta;
            sync_meta = {usr2_pwrgood_i, usr1_pwrgood_i};
        end
    end

endmodule

//--- tests/tb_sysctrl.sv
`timescale 1ns/1ps

module tb_sysctrl;

    localparam logic [31:0] SEED = 32'hd619cb22;
    localparam int MAX_CYCLES = 2000; // full run takes about 230 cycles.
    localparam int RESP_WAIT  = 4;

    logic        clk;
    logic        resetn;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        wb_err_o;
    logic        usr1_pwrgood_i;
    logic        usr2_pwrgood_i;
    logic        clk1_output_dest_o;
    logic        clk2_output_dest_o;
    logic        trap_output_dest_o;
    logic        irq_7_inputsrc_o;
    logic        irq_8_inputsrc_o;
    logic [1:0]  pwr_lost_o;

    logic [31:0] rng_state;
    logic [7:0]  ctrl_ofs [3] = '{sysctrl_pkg::OFS_CLK_OUT, sysctrl_pkg::OFS_TRAP_OUT,
                                  sysctrl_pkg::OFS_IRQ_SRC};
    string       cur_test;
    int          cycles = 0;
    int          tests = 0;
    int          tb_errors = 0;
    int          test_err_base = 0;

    sysctrl_wb sysctrl_wb_inst (.*);
    sysctrl_checker sysctrl_checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int total_errors();
        return tb_errors + sysctrl_checker_inst.errors;
    endfunction

    // ========================================
    // bus and test helpers
    // ========================================
    // called on a falling edge, returns on a falling edge.
    task automatic bus_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                              input logic [31:0] data, input logic expect_resp);
        int   waited;
        logic got;
        waited   = 0;
        got      = 1'b0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_sel_i = sel;
        wb_adr_i = adr;
        wb_dat_i = data;
        while (!got && waited < RESP_WAIT) begin
            @(negedge clk);
            waited++;
            got = wb_ack_o || wb_err_o;
        end
        if (got != expect_resp) begin
            tb_errors++;
            $display("[%s] access to %h: %s", cur_test, adr,
                     got ? "got a response that was not due" : "no ack or err within 4 cycles");
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk);
    endtask

    task automatic write_reg(input logic [7:0] ofs, input logic [3:0] sel,
                             input logic [31:0] data);
        bus_access(1'b1, sel, sysctrl_pkg::BASE_ADR | {24'd0, ofs}, data, 1'b1);
    endtask

    task automatic read_reg(input logic [7:0] ofs);
        bus_access(1'b0, 4'hF, sysctrl_pkg::BASE_ADR | {24'd0, ofs}, 32'd0, 1'b1);
    endtask

    task automatic settle_pwrgood(input logic [1:0] good);
        usr1_pwrgood_i = good[0];
        usr2_pwrgood_i = good[1];
        repeat (4) @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        sysctrl_checker_inst.test_name = name;
        test_err_base = total_errors();
    endtask

    task automatic end_test();
        tests++;
        $display("test %-12s %s (%0d errors)", cur_test,
                 (total_errors() == test_err_base) ? "ok" : "failed",
                 total_errors() - test_err_base);
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        logic [7:0] ofs_pick;
        wb_cyc_i       = 1'b0;
        wb_stb_i       = 1'b0;
        wb_we_i        = 1'b0;
        wb_sel_i       = 4'h0;
        wb_adr_i       = 32'd0;
        wb_dat_i       = 32'd0;
        usr1_pwrgood_i = 1'b1;
        usr2_pwrgood_i = 1'b1;
        resetn         = 1'b0;
        rng_state      = SEED;
        cur_test       = "reset";
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        begin_test("reset");
        for (int i = 0; i < 3; i++) read_reg(ctrl_ofs[i]);
        end_test();

        begin_test("ctrl_writes");
        for (int i = 0; i < 30; i++) begin
            rng_state = xorshift32(rng_state);
            ofs_pick  = ctrl_ofs[rng_state[9:8] % 2'd3];
            write_reg(ofs_pick, {rng_state[3:1], 1'b1}, rng_state);
            read_reg(ofs_pick);
        end
        end_test();

        begin_test("lane_rules");
        for (int i = 0; i < 3; i++) begin
            write_reg(ctrl_ofs[i], 4'hF, 32'd0);
            write_reg(ctrl_ofs[i], 4'b1110, 32'hFFFF_FFFF); // lane 0 off.
            read_reg(ctrl_ofs[i]);
        end
        write_reg(sysctrl_pkg::OFS_PWRGOOD, 4'hF, 32'd0);
        read_reg(sysctrl_pkg::OFS_PWRGOOD);
        end_test();

        begin_test("pwrgood");
        for (int v = 0; v < 4; v++) begin
            settle_pwrgood(v[1:0]);
            read_reg(sysctrl_pkg::OFS_PWRGOOD);
        end
        end_test();

        begin_test("loss_flags");
        write_reg(sysctrl_pkg::OFS_PWR_LOSS, 4'hF, 32'h3);
        read_reg(sysctrl_pkg::OFS_PWR_LOSS);
        settle_pwrgood(2'b10);
        read_reg(sysctrl_pkg::OFS_PWR_LOSS);
        settle_pwrgood(2'b11); // flag stays set.
        read_reg(sysctrl_pkg::OFS_PWR_LOSS);
        settle_pwrgood(2'b01);
        settle_pwrgood(2'b11);
        read_reg(sysctrl_pkg::OFS_PWR_LOSS);
        write_reg(sysctrl_pkg::OFS_PWR_LOSS, 4'hF, 32'h1);
        read_reg(sysctrl_pkg::OFS_PWR_LOSS);
        write_reg(sysctrl_pkg::OFS_PWR_LOSS, 4'hF, 32'h2);
        read_reg(sysctrl_pkg::OFS_PWR_LOSS);
        end_test();

        begin_test("decode");
        write_reg(sysctrl_pkg::OFS_CLK_OUT, 4'hF, 32'h2);
        write_reg(8'h20, 4'hF, 32'hFFFF_FFFF);
        read_reg(8'h20);
        read_reg(8'h02);
        bus_access(1'b1, 4'hF, 32'h3000_0004, 32'hFFFF_FFFF, 1'b0);
        bus_access(1'b1, 4'hF, 32'h2F00_0104, 32'hFFFF_FFFF, 1'b0);
        read_reg(sysctrl_pkg::OFS_CLK_OUT);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, sysctrl_checker_inst.checks,
                 total_errors());
        if (total_errors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
common/sysctrl_pkg.sv
src/sysctrl_bus.sv
sysctrl_regs/sysctrl_regs.sv
pwrgood_mon/pwrgood_mon.sv
src/sysctrl_wb.sv
tests/sysctrl_checker.sv
tests/tb_sysctrl.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_sysctrl -o tb_sysctrl

output=$(./obj_dir/tb_sysctrl)
echo "$output"

if grep -q "TEST RESULT: PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi
